/* hdl/addressHandler.sv */
`timescale 1ns/1ns
`default_nettype none

module addressHandler #(
  parameter logic [corePkg::wordWidth-1:0] privVector = 32'h100
) (
  input  corePkg::pcOp_t                  pcOp,
  input  corePkg::spOp_t                  spOp,
  input  logic [corePkg::wordWidth-1:0]   pc,
  input  logic [corePkg::wordWidth-1:0]   sp,
  input  logic [corePkg::wordWidth-1:0]   link,
  output logic [corePkg::wordWidth-1:0]   pcNext,
  output logic [corePkg::wordWidth-1:0]   spNext,
  output logic [corePkg::wordWidth-1:0]   stackAddr
);
  import corePkg::*;

  logic [wordWidth-1:0] spMinus;
  logic [wordWidth-1:0] spPlus;

  assign spMinus = sp - 1'b1;
  assign spPlus  = sp + 1'b1;

  always_comb begin
    case (pcOp)
      pcAdvance: pcNext = pc + 1'b1;
      pcVector:  pcNext = privVector;
      pcLink:    pcNext = link;   // RET
      default:   pcNext = pc;
    endcase
  end

  always_comb begin
    case (spOp)
      spDec:   spNext = spMinus;
      spInc:   spNext = spPlus;
      default: spNext = sp;
    endcase
  end

  // Full descending stack, push writes below the current SP
  assign stackAddr = (spOp == spDec) ? spMinus : sp;

endmodule

`default_nettype wire

/* hdl/aluUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
  input  corePkg::opcode_t                aluOp,
  input  logic                            useImm,
  input  logic [corePkg::wordWidth-1:0]   opA,
  input  logic [corePkg::wordWidth-1:0]   opB,
  input  logic [15:0]                     imm,
  output logic [corePkg::wordWidth-1:0]   result
);
  import corePkg::*;

  logic [wordWidth-1:0] immExt;
  logic [wordWidth-1:0] operand;

  assign immExt  = {{(wordWidth-16){imm[15]}}, imm}; // Sign extension
  assign operand = useImm ? immExt : opB;

  // Everything not listed adds, which covers ADDI, LOAD, STORE and SVC
  always_comb begin
    case (aluOp)
      opSub: begin
        result = opA - operand;
      end
      opAnd: begin
        result = opA & operand;
      end
      opOr: begin
        result = opA | operand;
      end
      default: begin
        result = opA + operand;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit #(
  parameter logic [corePkg::wordWidth-1:0] resetPc = '0
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [corePkg::wordWidth-1:0]   prdata,
  input  logic                            pready,
  input  logic [corePkg::wordWidth-1:0]   pc,
  input  logic [corePkg::wordWidth-1:0]   result,
  input  logic [corePkg::wordWidth-1:0]   stackAddr,
  input  logic [corePkg::wordWidth-1:0]   memOut,
  output logic [corePkg::wordWidth-1:0]   paddr,
  output logic [corePkg::wordWidth-1:0]   pwdata,
  output logic                            psel,
  output logic                            penable,
  output logic                            pwrite,
  output logic [3:0]                      regD,
  output logic [3:0]                      regA,
  output logic [3:0]                      regB,
  output logic [15:0]                     imm,
  output corePkg::opcode_t                aluOp,
  output logic                            useImm,
  output logic                            mode,
  output logic                            bankEnable,
  output corePkg::bankCtrl_t              bankCtrl,
  output corePkg::pcOp_t                  pcOp,
  output corePkg::spOp_t                  spOp,
  output logic [corePkg::wordWidth-1:0]   memIn
);
  import corePkg::*;

  state_t               state;
  state_t               stateNext;
  logic [wordWidth-1:0] instr;
  opcode_t              opcode;
  pcOp_t                pcOpDec;
  logic                 isStack;
  logic                 isMem;
  logic                 isWrite;
  logic                 inData;

  assign opcode  = opcode_t'(instr[31:28]);
  assign isStack = (opcode == opPush) || (opcode == opPop);
  assign isMem   = isStack || (opcode == opLoad) || (opcode == opStore);
  assign isWrite = (opcode == opStore) || (opcode == opPush);
  assign inData  = (state == memSetup) || (state == memAccess);

  // Idle bus parks the address at the boot location
  always_comb begin
    if (!psel) begin
      paddr = resetPc;
    end else if (inData) begin
      paddr = isStack ? stackAddr : result;
    end else begin
      paddr = pc; // Fetch
    end
  end

  assign pwrite     = inData && isWrite;
  assign pwdata     = memOut;
  assign bankEnable = (state == writeback);
  assign pcOp       = (state == writeback) ? pcOpDec : pcHold;

  always_comb begin
    case (state)
      fetchSetup:  stateNext = psel ? fetchAccess : fetchSetup; // Idle cycle after reset
      fetchAccess: stateNext = pready ? execute : fetchAccess;
      execute:     stateNext = isMem ? memSetup : writeback;
      memSetup:    stateNext = memAccess;
      memAccess:   stateNext = pready ? writeback : memAccess;
      writeback:   stateNext = fetchSetup;
      default:     stateNext = fetchSetup;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= fetchSetup;
      psel    <= 1'b0;
      penable <= 1'b0;
      mode    <= 1'b0;
    end else begin
      state   <= stateNext;
      psel    <= (stateNext != execute) && (stateNext != writeback);
      penable <= (stateNext == fetchAccess) || (stateNext == memAccess);
      if (state == writeback) begin
        if (opcode == opSvc) begin
          mode <= 1'b1;
        end else if (opcode == opRet) begin
          mode <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == fetchAccess && pready) begin
      instr <= prdata;
    end
    if (state == memAccess && pready && !isWrite) begin
      memIn <= prdata; // LOAD and POP data
    end
  end

  always_comb begin
    regD     = instr[27:24];
    regA     = instr[23:20];
    regB     = instr[19:16];
    imm      = instr[15:0];
    aluOp    = opcode;
    useImm   = 1'b0;
    bankCtrl = bankHold;
    spOp     = spKeep;
    pcOpDec  = pcAdvance;
    case (opcode)
      opAdd, opSub, opAnd, opOr: bankCtrl = bankResult;
      opAddi: begin
        useImm   = 1'b1;
        bankCtrl = bankResult;
      end
      opLoad: begin
        useImm   = 1'b1; // Address = ra + imm
        bankCtrl = bankMemIn;
      end
      opStore: useImm = 1'b1;
      opPush:  spOp = spDec;
      opPop: begin
        spOp     = spInc;
        bankCtrl = bankMemIn;
      end
      opSvc: begin
        // PC + 1 through the ALU becomes the link
        regA     = 4'd15;
        imm      = 16'd1;
        useImm   = 1'b1;
        aluOp    = opAdd;
        bankCtrl = bankEnterPriv;
        pcOpDec  = pcVector;
      end
      opRet: begin
        regA    = 4'd13; // Link onto busA
        pcOpDec = pcLink;
      end
      opRst: bankCtrl = bankRestart;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/corePkg.sv */
`default_nettype none

package corePkg;

  localparam int wordWidth = 32; // Data and address width

  // Instruction opcodes, bits 31..28 of the instruction word
  typedef enum logic [3:0] {
    opAdd   = 4'd0,
    opSub   = 4'd1,
    opAnd   = 4'd2,
    opOr    = 4'd3,
    opAddi  = 4'd4,
    opLoad  = 4'd5,
    opStore = 4'd6,
    opPush  = 4'd7,
    opPop   = 4'd8,
    opSvc   = 4'd9,  // Enter privileged mode
    opRet   = 4'd10, // Back to user mode
    opRst   = 4'd11  // Reload R0 and active SP
  } opcode_t;

  // Register bank write command
  typedef enum logic [2:0] {
    bankHold      = 3'd0, // No write
    bankResult    = 3'd1, // rd <= ALU result
    bankRestart   = 3'd2, // R0 <= dataStart, active SP <= all ones
    bankMemIn     = 3'd3, // rd <= read data
    bankEnterPriv = 3'd4  // R13 <= link address
  } bankCtrl_t;

  typedef enum logic [1:0] {
    spKeep = 2'd0,
    spDec  = 2'd1, // Push
    spInc  = 2'd2  // Pop
  } spOp_t;

  typedef enum logic [1:0] {
    pcHold    = 2'd0,
    pcAdvance = 2'd1, // PC + 1
    pcVector  = 2'd2, // SVC entry
    pcLink    = 2'd3  // RET target from R13
  } pcOp_t;

  typedef enum logic [2:0] {
    fetchSetup  = 3'd0,
    fetchAccess = 3'd1,
    execute     = 3'd2,
    memSetup    = 3'd3,
    memAccess   = 3'd4,
    writeback   = 3'd5
  } state_t;

endpackage

`default_nettype wire

/* hdl/miniCore.sv */
`timescale 1ns/1ns
`default_nettype none

module miniCore #(
  parameter logic [corePkg::wordWidth-1:0] resetPc    = '0,
  parameter logic [corePkg::wordWidth-1:0] dataStart  = 32'h8253,
  parameter logic [corePkg::wordWidth-1:0] privVector = 32'h100
) (
  input  logic                            clock,
  input  logic                            reset,
  output logic [corePkg::wordWidth-1:0]   paddr,
  output logic                            psel,
  output logic                            penable,
  output logic                            pwrite,
  output logic [corePkg::wordWidth-1:0]   pwdata,
  input  logic [corePkg::wordWidth-1:0]   prdata,
  input  logic                            pready
);
  import corePkg::*;

  logic [3:0]           regD;
  logic [3:0]           regA;
  logic [3:0]           regB;
  logic [15:0]          imm;
  logic                 bankEnable;
  logic                 mode;
  logic                 useImm;
  bankCtrl_t            bankCtrl;
  opcode_t              aluOp;
  pcOp_t                pcOp;
  spOp_t                spOp;
  logic [wordWidth-1:0] busA;
  logic [wordWidth-1:0] busB;
  logic [wordWidth-1:0] memOut;
  logic [wordWidth-1:0] memIn;
  logic [wordWidth-1:0] pc;
  logic [wordWidth-1:0] sp;
  logic [wordWidth-1:0] result;
  logic [wordWidth-1:0] pcNext;
  logic [wordWidth-1:0] spNext;
  logic [wordWidth-1:0] stackAddr;

  regBank #(.resetPc(resetPc), .dataStart(dataStart)) regBank_i (
    .clock(clock), .reset(reset), .bankEnable(bankEnable), .mode(mode),
    .bankCtrl(bankCtrl), .regD(regD), .regA(regA), .regB(regB),
    .result(result), .memIn(memIn), .pcNext(pcNext), .spNext(spNext),
    .busA(busA), .busB(busB), .memOut(memOut), .pc(pc), .sp(sp)
  );

  aluUnit aluUnit_i (
    .aluOp(aluOp), .useImm(useImm), .opA(busA), .opB(busB), .imm(imm), .result(result)
  );

  // RET selects R13 onto busA as the link
  addressHandler #(.privVector(privVector)) addressHandler_i (
    .pcOp(pcOp), .spOp(spOp), .pc(pc), .sp(sp), .link(busA),
    .pcNext(pcNext), .spNext(spNext), .stackAddr(stackAddr)
  );

  controlUnit #(.resetPc(resetPc)) controlUnit_i (
    .clock(clock), .reset(reset), .prdata(prdata), .pready(pready),
    .pc(pc), .result(result), .stackAddr(stackAddr), .memOut(memOut),
    .paddr(paddr), .pwdata(pwdata), .psel(psel), .penable(penable), .pwrite(pwrite),
    .regD(regD), .regA(regA), .regB(regB), .imm(imm), .aluOp(aluOp),
    .useImm(useImm), .mode(mode), .bankEnable(bankEnable), .bankCtrl(bankCtrl),
    .pcOp(pcOp), .spOp(spOp), .memIn(memIn)
  );

endmodule

`default_nettype wire

/* hdl/regBank.sv */
`timescale 1ns/1ns
`default_nettype none

module regBank #(
  parameter logic [corePkg::wordWidth-1:0] resetPc   = '0,
  parameter logic [corePkg::wordWidth-1:0] dataStart = 32'h8253
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            bankEnable,
  input  logic                            mode,       // 0 user, 1 privileged
  input  corePkg::bankCtrl_t              bankCtrl,
  input  logic [3:0]                      regD,
  input  logic [3:0]                      regA,
  input  logic [3:0]                      regB,
  input  logic [corePkg::wordWidth-1:0]   result,
  input  logic [corePkg::wordWidth-1:0]   memIn,
  input  logic [corePkg::wordWidth-1:0]   pcNext,
  input  logic [corePkg::wordWidth-1:0]   spNext,
  output logic [corePkg::wordWidth-1:0]   busA,
  output logic [corePkg::wordWidth-1:0]   busB,
  output logic [corePkg::wordWidth-1:0]   memOut,
  output logic [corePkg::wordWidth-1:0]   pc,
  output logic [corePkg::wordWidth-1:0]   sp
);
  import corePkg::*;

  logic [wordWidth-1:0] reg0;          // R0 has a reset value
  logic [wordWidth-1:0] regs [1:13];   // General registers, R13 doubles as link
  logic [wordWidth-1:0] pcReg;
  logic [wordWidth-1:0] userSp;
  logic [wordWidth-1:0] privSp;
  logic [wordWidth-1:0] writeData;
  logic                 writeHit;

  assign sp = mode ? privSp : userSp; // Active stack pointer
  assign pc = pcReg;

  // R14 reads the active SP, R15 reads the PC
  function automatic logic [wordWidth-1:0] readPort(input logic [3:0] sel);
    case (sel)
      4'd0:    readPort = reg0;
      4'd14:   readPort = sp;
      4'd15:   readPort = pcReg;
      default: readPort = regs[sel];
    endcase
  endfunction

  always_comb begin
    busA   = readPort(regA);
    busB   = readPort(regB);
    memOut = readPort(regD); // Store and push data
  end

  assign writeData = (bankCtrl == bankMemIn) ? memIn : result;
  // Writes to R14 and R15 are dropped
  assign writeHit = (bankCtrl == bankResult || bankCtrl == bankMemIn) && (regD < 4'd14);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      reg0   <= dataStart;
      pcReg  <= resetPc;
      userSp <= '1;
      privSp <= '1;
    end else if (bankEnable) begin
      pcReg <= pcNext;
      if (bankCtrl == bankRestart) begin
        reg0 <= dataStart;
        if (mode) begin // Only the active SP is reloaded
          privSp <= '1;
        end else begin
          userSp <= '1;
        end
      end else begin
        if (mode) begin
          privSp <= spNext;
        end else begin
          userSp <= spNext;
        end
        if (writeHit && regD == 4'd0) begin
          reg0 <= writeData;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (bankEnable) begin
      if (bankCtrl == bankEnterPriv) begin
        regs[13] <= result; // Link = address after the SVC
      end else if (writeHit && regD != 4'd0) begin
        regs[regD] <= writeData;
      end
    end
  end

endmodule

`default_nettype wire

/* project.f */
hdl/corePkg.sv
hdl/regBank.sv
hdl/aluUnit.sv
hdl/addressHandler.sv
hdl/controlUnit.sv
hdl/miniCore.sv
verification/miniCore_checker.sv
verification/miniCoreTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module miniCoreTb -f project.f -o miniCoreSim &&
./obj_dir/miniCoreSim | tee /dev/stderr | grep -qx "sim passed" &&
echo "RESULT: PASS" ||
{ echo "RESULT: FAIL"; exit 1; }

/* verification/miniCoreTb.sv */
`timescale 1ns/1ns
`default_nettype none

module miniCoreTb;
  import corePkg::*;

  localparam logic [wordWidth-1:0] resetPc    = 32'h0;
  localparam logic [wordWidth-1:0] dataStart  = 32'h8253;
  localparam logic [wordWidth-1:0] privVector = 32'h100;
  localparam int numSteps   = 35; // Instructions executed including the handler
  localparam int cycleLimit = 40 * numSteps;

  logic                 clock;
  logic                 reset;
  logic [wordWidth-1:0] paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [wordWidth-1:0] pwdata;
  logic [wordWidth-1:0] prdata;
  logic                 pready;

  logic [wordWidth-1:0] mem [logic [wordWidth-1:0]];   // Bus side memory
  logic [wordWidth-1:0] shMem [logic [wordWidth-1:0]]; // Shadow model memory
  logic [wordWidth-1:0] shRegs [0:13];
  logic [wordWidth-1:0] shPc;
  logic [wordWidth-1:0] shUserSp;
  logic [wordWidth-1:0] shPrivSp;
  logic                 shPriv;
  logic [wordWidth-1:0] expAddr [$];
  logic [wordWidth-1:0] expData [$];
  logic                 expWrite [$];
  string                expName [$];
  int                   seed = 32'hc3f09586;
  int                   waitLeft;
  int                   checkedCount = 0;
  int                   cycleCount = 0;
  logic                 runDone = 1'b0;
  logic                 runPassed = 1'b0;
  logic                 failShown = 1'b0;

  miniCore #(.resetPc(resetPc), .dataStart(dataStart), .privVector(privVector)) dut_i (
    .clock(clock), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready)
  );

  bind miniCore miniCore_checker checker_i (
    .clock(clock), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .pready(pready)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic stopWithFailure(input string msg);
    failShown = 1'b1;
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic reportMismatch(input string name, input logic [wordWidth-1:0] expected,
      input logic [wordWidth-1:0] actual);
    stopWithFailure($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
  endtask

  function automatic logic [wordWidth-1:0] fillWord(input logic [wordWidth-1:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5a3c96e1; // Unwritten words
  endfunction

  function automatic logic [wordWidth-1:0] busRead(input logic [wordWidth-1:0] addr);
    return mem.exists(addr) ? mem[addr] : fillWord(addr);
  endfunction

  function automatic logic [wordWidth-1:0] shadowRead(input logic [wordWidth-1:0] addr);
    return shMem.exists(addr) ? shMem[addr] : fillWord(addr);
  endfunction

  function automatic logic [wordWidth-1:0] readReg(input logic [3:0] idx);
    if (idx == 4'd14) begin
      return shPriv ? shPrivSp : shUserSp; // Active SP
    end
    return (idx == 4'd15) ? shPc : shRegs[idx];
  endfunction

  function automatic void writeReg(input logic [3:0] idx, input logic [wordWidth-1:0] value);
    if (idx < 4'd14) begin
      shRegs[idx] = value; // R14 and R15 ignore writes
    end
  endfunction

  function automatic void setSp(input logic [wordWidth-1:0] value);
    if (shPriv) begin
      shPrivSp = value;
    end else begin
      shUserSp = value;
    end
  endfunction

  function automatic void expectTransfer(input logic [wordWidth-1:0] addr, input logic write,
      input logic [wordWidth-1:0] data, input string name);
    expAddr.push_back(addr);
    expWrite.push_back(write);
    expData.push_back(data);
    expName.push_back(name);
  endfunction

  function automatic void placeInstr(input logic [wordWidth-1:0] addr, input opcode_t op,
      input logic [3:0] rd, input logic [3:0] ra, input logic [3:0] rb, input logic [15:0] imm);
    mem[addr] = {op, rd, ra, rb, imm};
  endfunction

  task automatic loadProgram();
    placeInstr(0, opSub, 1, 0, 0, 0);            // R1 = 0 as the data base
    placeInstr(1, opStore, 0, 1, 0, 16'h200);    // R0 reset value
    placeInstr(2, opAddi, 2, 0, 0, 16'hfffb);    // Negative immediate
    placeInstr(3, opAddi, 3, 1, 0, 16'h1234);
    placeInstr(4, opAdd, 4, 2, 3, 0);
    placeInstr(5, opSub, 5, 3, 2, 0);
    placeInstr(6, opAnd, 6, 2, 3, 0);
    placeInstr(7, opOr, 7, 2, 3, 0);
    placeInstr(8, opStore, 4, 1, 0, 16'h201);
    placeInstr(9, opStore, 5, 1, 0, 16'h202);
    placeInstr(10, opStore, 6, 1, 0, 16'h203);
    placeInstr(11, opStore, 7, 1, 0, 16'h204);
    placeInstr(12, opAddi, 14, 1, 0, 16'h7);     // SP write dropped
    placeInstr(13, opAddi, 15, 1, 0, 16'h50);    // PC write dropped
    placeInstr(14, opStore, 14, 1, 0, 16'h205);
    placeInstr(15, opPush, 4, 0, 0, 0);
    placeInstr(16, opPush, 5, 0, 0, 0);
    placeInstr(17, opPop, 8, 0, 0, 0);
    placeInstr(18, opStore, 8, 1, 0, 16'h206);
    placeInstr(19, opLoad, 9, 1, 0, 16'h300);
    placeInstr(20, opStore, 9, 1, 0, 16'h207);
    placeInstr(21, opSvc, 0, 0, 0, 0);
    placeInstr(22, opStore, 14, 1, 0, 16'h20c);  // User SP after RET
    placeInstr(23, opAddi, 0, 1, 0, 16'h99);
    placeInstr(24, opRst, 0, 0, 0, 0);
    placeInstr(25, opStore, 0, 1, 0, 16'h20d);
    placeInstr(26, opStore, 14, 1, 0, 16'h20e);
    placeInstr(privVector, opStore, 13, 1, 0, 16'h208);     // Link
    placeInstr(privVector + 1, opStore, 14, 1, 0, 16'h209); // Privileged SP
    placeInstr(privVector + 2, opPush, 2, 0, 0, 0);
    placeInstr(privVector + 3, opAddi, 0, 1, 0, 16'h77);
    placeInstr(privVector + 4, opRst, 0, 0, 0, 0);
    placeInstr(privVector + 5, opStore, 0, 1, 0, 16'h20a);
    placeInstr(privVector + 6, opStore, 14, 1, 0, 16'h20b);
    placeInstr(privVector + 7, opRet, 0, 0, 0, 0);
    mem[32'h300] = 32'h13579bdf; // LOAD source
  endtask

  // Shadow model of the instruction rules with one expected transfer per bus access
  task automatic buildExpected();
    logic [wordWidth-1:0] ir;
    logic [wordWidth-1:0] opA;
    logic [wordWidth-1:0] opB;
    logic [wordWidth-1:0] immExt;
    logic [wordWidth-1:0] addr;
    logic [wordWidth-1:0] nextPc;
    logic [3:0]           rd;
    opcode_t              op;
    string                tag;
    shMem = mem;
    shRegs = '{default: '0};
    shRegs[0] = dataStart;
    shPc = resetPc;
    shUserSp = '1;
    shPrivSp = '1;
    shPriv = 1'b0;
    for (int step = 0; step < numSteps; step++) begin
      ir = shadowRead(shPc);
      expectTransfer(shPc, 1'b0, '0, $sformatf("fetch %0d", step));
      op = opcode_t'(ir[31:28]);
      rd = ir[27:24];
      opA = readReg(ir[23:20]);
      opB = readReg(ir[19:16]);
      immExt = {{16{ir[15]}}, ir[15:0]};
      tag = $sformatf("%s at %h", op.name(), shPc);
      nextPc = shPc + 1;
      case (op)
        opAdd:  writeReg(rd, opA + opB);
        opSub:  writeReg(rd, opA - opB);
        opAnd:  writeReg(rd, opA & opB);
        opOr:   writeReg(rd, opA | opB);
        opAddi: writeReg(rd, opA + immExt);
        opLoad: begin
          addr = opA + immExt;
          expectTransfer(addr, 1'b0, '0, tag);
          writeReg(rd, shadowRead(addr));
        end
        opStore: begin
          addr = opA + immExt;
          expectTransfer(addr, 1'b1, readReg(rd), tag);
          shMem[addr] = readReg(rd);
        end
        opPush: begin
          addr = readReg(4'd14) - 1; // Full descending stack
          expectTransfer(addr, 1'b1, readReg(rd), tag);
          shMem[addr] = readReg(rd);
          setSp(addr);
        end
        opPop: begin
          addr = readReg(4'd14);
          expectTransfer(addr, 1'b0, '0, tag);
          setSp(addr + 1);
          writeReg(rd, shadowRead(addr));
        end
        opSvc: begin
          shRegs[13] = shPc + 1;
          nextPc = privVector;
          shPriv = 1'b1;
        end
        opRet: begin
          nextPc = shRegs[13];
          shPriv = 1'b0;
        end
        opRst: begin
          shRegs[0] = dataStart;
          setSp('1); // Active mode only
        end
        default: ;
      endcase
      shPc = nextPc;
    end
  endtask

  task automatic checkTransfer();
    if (checkedCount >= expAddr.size()) begin
      stopWithFailure("DUT started a bus transfer after the program ended");
    end else begin
      assert (pwrite == expWrite[checkedCount])
        else stopWithFailure($sformatf("%s has the wrong transfer direction",
          expName[checkedCount]));
      assert (paddr == expAddr[checkedCount])
        else reportMismatch({expName[checkedCount], " address"}, expAddr[checkedCount], paddr);
      if (pwrite) begin
        assert (pwdata == expData[checkedCount])
          else reportMismatch({expName[checkedCount], " data"}, expData[checkedCount], pwdata);
        mem[paddr] = pwdata;
      end else begin
        prdata <= busRead(paddr);
      end
      checkedCount++;
      if (checkedCount == expAddr.size()) begin
        runDone = 1'b1; // Final store seen
      end
    end
  endtask

  // APB slave with random wait states
  always @(negedge clock) begin
    if (psel && !penable) begin
      waitLeft = $unsigned($random(seed)) % 4;
      pready <= 1'b0;
    end else if (psel && penable) begin
      if (waitLeft == 0) begin
        checkTransfer();
        pready <= 1'b1;
      end else begin
        waitLeft = waitLeft - 1;
        pready <= 1'b0;
      end
    end else begin
      pready <= 1'b0;
    end
  end

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == cycleLimit) begin
      stopWithFailure($sformatf("timeout, program not finished after %0d cycles", cycleLimit));
    end
  end

  initial begin
    reset = 1'b1;
    prdata = '0;
    pready = 1'b0;
    waitLeft = 0;
    loadProgram();
    buildExpected();
    repeat (10) @(negedge clock);
    reset = 1'b0;
    wait (runDone);
    runPassed = 1'b1;
    $display("sim passed");
    $finish;
  end

  final begin
    if (!runPassed && !failShown) begin
      $display("sim failed"); // Stopped by a bound assertion
    end
  end

endmodule

`default_nettype wire

/* verification/miniCore_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module miniCore_checker (
  input logic                            clock,
  input logic                            reset,
  input logic [corePkg::wordWidth-1:0]   paddr,
  input logic                            psel,
  input logic                            penable,
  input logic                            pwrite,
  input logic [corePkg::wordWidth-1:0]   pwdata,
  input logic                            pready
);

  // Bus stays idle while reset is held
  resetIdle: assert property (@(posedge clock) reset |-> !psel && !penable)
    else $error("APB select or enable active during reset");

  // Setup cycle is followed by the access cycle
  setupToAccess: assert property (@(posedge clock) disable iff (reset)
    psel && !penable |=> psel && penable)
    else $error("penable did not follow psel by one cycle");

  enableNeedsSelect: assert property (@(posedge clock) disable iff (reset)
    penable |-> psel)
    else $error("penable high without psel");

  // Address, direction and write data hold until completion
  holdUntilDone: assert property (@(posedge clock) disable iff (reset)
    psel && !(penable && pready) |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else $error("APB address, direction or write data changed before completion");

endmodule

`default_nettype wire
